/* vlog.f */
src/isa_pkg.sv
src/core_pkg.sv
src/insn_fetch.sv
src/insn_queue.sv
src/insn_decode.sv
src/dispatch_stage.sv
src/frontend_top.sv
verification/tb_frontend.sv

/* verification/tb_frontend.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_frontend import isa_pkg::*; import core_pkg::*; ();

  localparam int  prog_len    = 34;
  localparam int  clk_period  = 40;
  localparam time watchdog_ns = prog_len * 8 * clk_period;

  logic    in_clk;
  logic    rst_n;
  wb_s2m_t wb_in;
  logic    uop_ready;
  wb_m2s_t wb_out;
  uop_t    uop;
  logic    uop_valid;
  logic    halted;

  // Program words with the decode each one must produce.
  logic [31:0] prog_insn [prog_len];
  opcode_t     prog_op   [prog_len];
  logic [4:0]  prog_src1 [prog_len];
  logic [4:0]  prog_src2 [prog_len];
  logic [4:0]  prog_dst  [prog_len];
  logic [63:0] prog_imm  [prog_len];
  logic        prog_wr   [prog_len];

  int          seed = 32'h27a7_c2b6;
  int          n_load;
  int          n_errors;
  int          n_checks;
  int          n_xfer;
  int          waits;
  int          stall_left;
  int          stall_cnt;
  logic        in_read;
  logic [31:0] exp_adr;

  frontend_top i_dut (
    .in_clk    (in_clk),
    .rst_n     (rst_n),
    .wb_in     (wb_in),
    .uop_ready (uop_ready),
    .wb_out    (wb_out),
    .uop       (uop),
    .uop_valid (uop_valid),
    .halted    (halted)
  );

  initial in_clk = 1'b0;
  always #(clk_period / 2) in_clk = ~in_clk;

  task automatic flag_error(input string msg);
    n_errors = n_errors + 1;
    $display("ERROR at %0d ns: %s", $time, msg);
  endtask

  task automatic check_field(input string name, input logic [63:0] exp, input logic [63:0] act);
    n_checks = n_checks + 1;
    assert (act === exp) else begin
      n_errors = n_errors + 1;
      $display("FAILED at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  task automatic add_insn(input logic [31:0] insn, input opcode_t op, input logic [4:0] s1,
                          input logic [4:0] s2, input logic [4:0] d, input logic [63:0] imm,
                          input logic wr);
    prog_insn[n_load] = insn;
    prog_op[n_load]   = op;
    prog_src1[n_load] = s1;
    prog_src2[n_load] = s2;
    prog_dst[n_load]  = d;
    prog_imm[n_load]  = imm;
    prog_wr[n_load]   = wr;
    n_load = n_load + 1;
  endtask

  // One word per opcode, two undefined words, then HLT.
  task automatic load_program();
    add_insn({11'b11111000010, 9'h0a5, 2'b00, 5'd3, 5'd4}, op_ldur, 3, 0, 4, 'h0a5, 1);
    add_insn({11'b11111000000, 9'h1c3, 2'b00, 5'd5, 5'd6}, op_stur, 5, 6, 0, 'h1c3, 0);
    add_insn({10'b1010100011, 7'd2, 5'd7, 5'd8, 5'd9}, op_ldp, 8, 0, 9, 0, 1);
    add_insn({10'b1010100100, 7'd3, 5'd10, 5'd11, 5'd12}, op_stp, 11, 0, 12, 0, 1);
    add_insn({9'b111100101, 2'b00, 16'hbeef, 5'd13}, op_movk, 0, 0, 13, 'hbeef, 1);
    add_insn({1'b0, 2'b01, 5'b10000, 19'h12345, 5'd14}, op_adr, 0, 0, 14, 0, 1);
    // Page form puts immhi:immlo above twelve zero bits.
    add_insn({1'b1, 2'b10, 5'b10000, 19'h00abc, 5'd15}, op_adrp, 0, 0, 15, 'h2af2000, 1);
    add_insn({11'b10011010100, 5'd16, 4'h1, 2'b01, 5'd17, 5'd18}, op_csinc, 17, 16, 18, 0, 1);
    add_insn({11'b11011010100, 5'd19, 4'h2, 2'b00, 5'd20, 5'd21}, op_csinv, 20, 19, 21, 0, 1);
    add_insn({11'b11011010100, 5'd22, 4'h3, 2'b01, 5'd23, 5'd24}, op_csneg, 23, 22, 24, 0, 1);
    add_insn({11'b10011010100, 5'd25, 4'h4, 2'b00, 5'd26, 5'd27}, op_csel, 26, 25, 27, 0, 1);
    add_insn({9'b100100010, 1'b0, 12'h7ff, 5'd1, 5'd2}, op_add, 1, 0, 2, 'h7ff, 1);
    add_insn({11'b10101011000, 5'd3, 6'd0, 5'd4, 5'd5}, op_adds, 4, 3, 5, 0, 1);
    add_insn({9'b110100010, 1'b0, 12'h123, 5'd6, 5'd7}, op_sub, 6, 0, 7, 'h123, 1);
    add_insn({11'b11101011000, 5'd8, 6'd0, 5'd9, 5'd10}, op_subs, 9, 8, 10, 0, 1);
    add_insn({11'b10101010001, 5'd11, 6'd0, 5'd12, 5'd13}, op_orn, 12, 11, 13, 0, 1);
    add_insn({11'b10101010000, 5'd14, 6'd0, 5'd15, 5'd16}, op_orr, 15, 14, 16, 0, 1);
    add_insn({11'b11001010000, 5'd17, 6'd0, 5'd18, 5'd19}, op_eor, 18, 17, 19, 0, 1);
    add_insn({10'b1001001000, 6'd1, 6'd2, 5'd20, 5'd21}, op_and, 20, 0, 21, 0, 1);
    add_insn({11'b11101010000, 5'd22, 6'd0, 5'd23, 5'd24}, op_ands, 23, 22, 24, 0, 1);
    // Bitfield immediates are immr:imms.
    add_insn({10'b1101001101, 6'd4, 6'd63, 5'd25, 5'd26}, op_ubfm, 25, 0, 26, 'h13f, 1);
    add_insn({10'b1001001101, 6'd8, 6'd31, 5'd27, 5'd28}, op_sbfm, 27, 0, 28, 'h21f, 1);
    add_insn({6'b000101, 26'h0000010}, op_b, 0, 0, 0, 0, 0);
    add_insn({8'b01010100, 19'h00020, 1'b0, 4'h1}, op_b_cond, 0, 0, 0, 0, 0);
    add_insn({6'b100101, 26'h0000040}, op_bl, 0, 0, 30, 0, 1);
    add_insn({22'b1101011000111111000000, 5'd7, 5'd0}, op_blr, 7, 0, 0, 0, 1);
    add_insn({22'b1101011000011111000000, 5'd8, 5'd0}, op_br, 8, 0, 0, 0, 0);
    add_insn({8'b10110100, 19'h00010, 5'd9}, op_cbz, 9, 0, 0, 0, 0);
    add_insn({8'b10110101, 19'h00010, 5'd10}, op_cbnz, 10, 0, 0, 0, 0);
    add_insn({22'b1101011001011111000000, 5'd30, 5'd0}, op_ret, 30, 0, 0, 0, 0);
    add_insn(32'hd503_201f, op_nop, 0, 0, 0, 0, 0);
    add_insn(32'h0000_0000, op_err, 0, 0, 0, 0, 1);
    add_insn(32'hffff_ffff, op_err, 31, 0, 31, 0, 1);
    add_insn({11'b11010100010, 16'h0000, 5'd0}, op_hlt, 0, 0, 0, 0, 0);
  endtask

  // Words past the program get an address-dependent fill.
  function automatic logic [31:0] mem_word(input logic [31:0] adr);
    logic [31:0] idx;
    idx = (adr - reset_vector) >> 2;
    if (idx < prog_len) begin
      return prog_insn[idx];
    end else begin
      return adr ^ 32'h5a5a_c3c3;
    end
  endfunction

  // ALU operation an instruction calls for. Addresses and branches add.
  function automatic alu_op_t expected_alu_op(input opcode_t op);
    case (op)
      op_sub, op_subs: return alu_op_minus;
      op_orn:          return alu_op_orn;
      op_orr:          return alu_op_or;
      op_eor:          return alu_op_eor;
      op_and, op_ands: return alu_op_and;
      op_ubfm:         return alu_op_ubfm;
      op_sbfm:         return alu_op_sbfm;
      op_movk:         return alu_op_mov;
      op_csel:         return alu_op_csel;
      op_csinc:        return alu_op_csinc;
      op_csinv:        return alu_op_csinv;
      op_csneg:        return alu_op_csneg;
      default:         return alu_op_plus;
    endcase
  endfunction

  task automatic check_uop();
    if (n_xfer >= prog_len) begin
      flag_error("micro-op transferred beyond the HLT at the end of the program");
    end else begin
      check_field("uop.pc", reset_vector + 32'(4 * n_xfer), uop.pc);
      check_field("uop.opcode", prog_op[n_xfer], uop.opcode);
      check_field("uop.alu_op", expected_alu_op(prog_op[n_xfer]), uop.alu_op);
      check_field("uop.src1", prog_src1[n_xfer], uop.src1);
      check_field("uop.src2", prog_src2[n_xfer], uop.src2);
      check_field("uop.dst", prog_dst[n_xfer], uop.dst);
      check_field("uop.imm", prog_imm[n_xfer], uop.imm);
      check_field("uop.fu", (prog_op[n_xfer] inside {op_ldur, op_stur, op_ldp, op_stp})
                  ? fu_ls : fu_alu, uop.fu);
      check_field("uop.w_enable", prog_wr[n_xfer], uop.w_enable);
      check_field("uop.set_cc", prog_op[n_xfer] inside {op_adds, op_subs, op_ands}, uop.set_cc);
      check_field("uop.dmem_read", prog_op[n_xfer] == op_ldur, uop.dmem_read);
      check_field("uop.dmem_write", prog_op[n_xfer] == op_stur, uop.dmem_write);
    end
  endtask

  // Wishbone slave with 0 to 3 wait states.
  task automatic drive_memory();
    if (wb_in.ack) begin
      wb_in   = '0;
      exp_adr = exp_adr + 32'd4;
    end else if (wb_out.cyc) begin
      if (!in_read) begin
        in_read = 1'b1;
        waits   = $random(seed) & 3;
        check_field("wb_out.adr", exp_adr, wb_out.adr);
      end
      if (waits == 0) begin
        wb_in.ack = 1'b1;
        wb_in.dat = mem_word(wb_out.adr);
        in_read   = 1'b0;
      end else begin
        waits = waits - 1;
      end
    end
  endtask

  // Random ready with one long stall after the ninth transfer.
  task automatic drive_backend();
    logic [31:0] rnd;
    rnd = $random(seed);
    if (stall_left > 0) begin
      uop_ready  = 1'b0;
      stall_left = stall_left - 1;
    end else begin
      uop_ready = rnd[0];
    end
    stall_cnt = uop_ready ? 0 : stall_cnt + 1;
    if (uop_valid && uop_ready) begin
      check_uop();
      n_xfer = n_xfer + 1;
      if (n_xfer == 9) begin
        stall_left = 44;
      end
    end
  endtask

  // One process drives all inputs, so the random sequence is fixed.
  always @(posedge in_clk) begin
    #2;
    drive_memory();
    drive_backend();
  end

  // Quiet bus and back end during and right after reset.
  assert property (@(posedge in_clk) !rst_n || $rose(rst_n) |-> !wb_out.cyc && !uop_valid
                   && !halted)
    else flag_error("outputs not idle during or right after reset");
  assert property (@(posedge in_clk) wb_out.stb == wb_out.cyc && !wb_out.we)
    else flag_error("stb differs from cyc, or we is high");
  assert property (@(posedge in_clk) wb_out.cyc && !wb_in.ack |=> wb_out.cyc
                   && $stable(wb_out.adr))
    else flag_error("bus cycle ended or address moved before ack");
  assert property (@(posedge in_clk) wb_in.ack |=> !wb_out.cyc)
    else flag_error("cyc still high in the cycle after ack");
  // Full and halted are sampled on the edge that opened the cycle.
  assert property (@(posedge in_clk) $rose(wb_out.cyc) |-> !$past(i_dut.full)
                   && !$past(halted))
    else flag_error("bus cycle opened with the queue full or after halt");
  assert property (@(posedge in_clk) stall_cnt > 36 |-> !wb_out.cyc)
    else flag_error("fetch keeps reading while the back end is stalled");
  assert property (@(posedge in_clk) uop_valid && !uop_ready |=> uop_valid && $stable(uop))
    else flag_error("micro-op changed or dropped while waiting for ready");
  assert property (@(posedge in_clk) uop_valid && uop_ready && uop.opcode == op_hlt |=> halted)
    else flag_error("halted did not rise after the HLT transfer");
  assert property (@(posedge in_clk) $rose(halted) |-> $past(uop_valid && uop_ready
                   && uop.opcode == op_hlt))
    else flag_error("halted rose without a HLT transfer");
  assert property (@(posedge in_clk) halted |=> halted && !uop_valid)
    else flag_error("halted dropped, or a micro-op was offered after halt");

  initial begin
    n_load     = 0;
    n_errors   = 0;
    n_checks   = 0;
    n_xfer     = 0;
    waits      = 0;
    stall_left = 0;
    stall_cnt  = 0;
    in_read    = 1'b0;
    exp_adr    = reset_vector;
    rst_n      = 1'b0;
    uop_ready  = 1'b0;
    wb_in      = '0;
    load_program();
    repeat (10) @(posedge in_clk);
    #2;
    rst_n = 1'b1;
    wait (halted === 1'b1);
    // Let any late bus cycle or transfer show up.
    repeat (20) @(posedge in_clk);
    if (n_xfer != prog_len) begin
      flag_error($sformatf("%0d of %0d micro-ops transferred", n_xfer, prog_len));
    end
    $display("Checks: %0d, transfers: %0d, errors: %0d", n_checks, n_xfer, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Timeout after %0d ns, HLT never reached halt", watchdog_ns);
    $display("Checks: %0d, transfers: %0d, errors: %0d", n_checks, n_xfer, n_errors + 1);
    $display("Test failures found");
    $finish;
  end

endmodule : tb_frontend

`default_nettype wire

/* src/frontend_top.sv */
`timescale 1ns/10ps
`default_nettype none

module frontend_top import core_pkg::*; (
  input  logic    in_clk,
  input  logic    rst_n,
  input  wb_s2m_t wb_in,
  input  logic    uop_ready,
  output wb_m2s_t wb_out,
  output uop_t    uop,
  output logic    uop_valid,
  output logic    halted
);

  fetch_pkt_t push_pkt;
  fetch_pkt_t head_pkt;
  logic       push;
  logic       pop;
  logic       full;
  logic       empty;

  // Bus master, stalls on a full queue or once halted.
  insn_fetch i_fetch (
    .in_clk (in_clk),
    .rst_n  (rst_n),
    .wb_in  (wb_in),
    .full   (full),
    .halted (halted),
    .wb_out (wb_out),
    .push   (push),
    .pkt    (push_pkt)
  );

  insn_queue i_queue (
    .in_clk   (in_clk),
    .rst_n    (rst_n),
    .push     (push),
    .push_pkt (push_pkt),
    .pop      (pop),
    .head_pkt (head_pkt),
    .full     (full),
    .empty    (empty)
  );

  // Decode and hand off to the back end.
  dispatch_stage i_dispatch (
    .in_clk    (in_clk),
    .rst_n     (rst_n),
    .head_pkt  (head_pkt),
    .empty     (empty),
    .uop_ready (uop_ready),
    .pop       (pop),
    .uop       (uop),
    .uop_valid (uop_valid),
    .halted    (halted)
  );

endmodule : frontend_top

`default_nettype wire

/* src/dispatch_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module dispatch_stage import isa_pkg::*; import core_pkg::*; (
  input  logic       in_clk,
  input  logic       rst_n,
  input  fetch_pkt_t head_pkt,
  input  logic       empty,
  input  logic       uop_ready,
  output logic       pop,
  output uop_t       uop,
  output logic       uop_valid,
  output logic       halted
);

  uop_t dec_uop;
  logic xfer;
  logic hlt_xfer;

  insn_decode i_decode (
    .insn (head_pkt.insn),
    .pc   (head_pkt.pc),
    .uop  (dec_uop)
  );

  assign xfer     = uop_valid && uop_ready;
  assign hlt_xfer = xfer && (uop.opcode == op_hlt);

  // Refill when empty or draining, but nothing follows a HLT.
  assign pop = !empty && !halted && (!uop_valid || (xfer && !hlt_xfer));

  // Holding register toward the back end.
  always_ff @(posedge in_clk) begin
    if (pop) begin
      uop <= dec_uop;
    end
  end

  always_ff @(posedge in_clk or negedge rst_n) begin
    if (!rst_n) begin
      uop_valid <= 1'b0;
      halted    <= 1'b0;
    end else begin
      if (pop) begin
        uop_valid <= 1'b1;
      end else if (xfer) begin
        uop_valid <= 1'b0;
      end
      // Sticky until reset.
      if (hlt_xfer) begin
        halted <= 1'b1;
      end
    end
  end

endmodule : dispatch_stage

`default_nettype wire

/* src/insn_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module insn_decode import isa_pkg::*; import core_pkg::*; (
  input  logic [31:0] insn,
  input  logic [31:0] pc,
  output uop_t        uop
);

  opcode_t                 opcode;
  alu_op_t                 alu_op;
  func_unit_t              fu;
  logic [63:0]             imm;
  logic [gpr_idx_size-1:0] src1;
  logic [gpr_idx_size-1:0] src2;
  logic [gpr_idx_size-1:0] dst;

  // Opcode match. First matching pattern wins.
  always_comb begin
    casez (insn)
      32'b1111_1000_010?_????_????_00??_????_????: opcode = op_ldur;
      32'b1111_1000_000?_????_????_00??_????_????: opcode = op_stur;
      32'b1010_1000_11??_????_????_????_????_????: opcode = op_ldp;
      32'b1010_1001_00??_????_????_????_????_????: opcode = op_stp;
      32'b1111_0010_1???_????_????_????_????_????: opcode = op_movk;
      32'b0??1_0000_????_????_????_????_????_????: opcode = op_adr;
      32'b1??1_0000_????_????_????_????_????_????: opcode = op_adrp;
      32'b1001_1010_100?_????_????_01??_????_????: opcode = op_csinc;
      32'b1101_1010_100?_????_????_00??_????_????: opcode = op_csinv;
      32'b1101_1010_100?_????_????_01??_????_????: opcode = op_csneg;
      32'b1001_1010_100?_????_????_00??_????_????: opcode = op_csel;
      // Immediate add and sub. Bit 22 is the shift flag.
      32'b1001_0001_0???_????_????_????_????_????: opcode = op_add;
      32'b1010_1011_000?_????_????_????_????_????: opcode = op_adds;
      32'b1101_0001_0???_????_????_????_????_????: opcode = op_sub;
      32'b1110_1011_000?_????_????_????_????_????: opcode = op_subs;
      32'b1010_1010_001?_????_????_????_????_????: opcode = op_orn;
      32'b1010_1010_000?_????_????_????_????_????: opcode = op_orr;
      32'b1100_1010_000?_????_????_????_????_????: opcode = op_eor;
      32'b1001_0010_00??_????_????_????_????_????: opcode = op_and;
      32'b1110_1010_000?_????_????_????_????_????: opcode = op_ands;
      32'b1101_0011_01??_????_????_????_????_????: opcode = op_ubfm;
      32'b1001_0011_01??_????_????_????_????_????: opcode = op_sbfm;
      32'b0001_01??_????_????_????_????_????_????: opcode = op_b;
      32'b0101_0100_????_????_????_????_???0_????: opcode = op_b_cond;
      32'b1001_01??_????_????_????_????_????_????: opcode = op_bl;
      32'b1101_0110_0011_1111_0000_00??_???0_0000: opcode = op_blr;
      32'b1101_0110_0001_1111_0000_00??_???0_0000: opcode = op_br;
      32'b1011_0101_????_????_????_????_????_????: opcode = op_cbnz;
      32'b1011_0100_????_????_????_????_????_????: opcode = op_cbz;
      32'b1101_0110_0101_1111_0000_00??_???0_0000: opcode = op_ret;
      32'b1101_0101_0000_0011_0010_0000_0001_1111: opcode = op_nop;
      32'b1101_0100_010?_????_????_????_???0_0000: opcode = op_hlt;
      default:                                     opcode = op_err;
    endcase
  end

  // Zero-extended immediate.
  always_comb begin
    case (opcode)
      op_ldur, op_stur:                imm = {55'd0, insn[20:12]};
      op_add, op_sub, op_ubfm, op_sbfm: imm = {52'd0, insn[21:10]};
      op_movk:                         imm = {48'd0, insn[20:5]};
      // Page offset with the low 12 bits cleared.
      op_adrp: imm = {31'd0, insn[23:5], insn[30:29], 12'h000};
      default: imm = 64'd0;
    endcase
  end

  // Register indices.
  always_comb begin
    // Destination.
    case (opcode)
      op_bl: dst = 5'd30;
      op_b, op_br, op_b_cond, op_blr, op_ret, op_nop, op_hlt,
      op_cbz, op_cbnz, op_stur: dst = '0;
      default: dst = insn[4:0];
    endcase
    // First source. Compare-and-branch tests Rt.
    case (opcode)
      op_cbz, op_cbnz: src1 = insn[4:0];
      op_movk, op_adr, op_adrp, op_b, op_b_cond, op_bl,
      op_nop, op_hlt: src1 = '0;
      default: src1 = insn[9:5];
    endcase
    // Second source. Store data or register operand.
    case (opcode)
      op_stur: src2 = insn[4:0];
      op_adds, op_subs, op_orn, op_orr, op_eor, op_ands,
      op_csel, op_csinc, op_csinv, op_csneg: src2 = insn[20:16];
      default: src2 = '0;
    endcase
  end

  // ALU operation. Address forms use plus.
  always_comb begin
    case (opcode)
      op_sub, op_subs: alu_op = alu_op_minus;
      op_orn:          alu_op = alu_op_orn;
      op_orr:          alu_op = alu_op_or;
      op_eor:          alu_op = alu_op_eor;
      op_and, op_ands: alu_op = alu_op_and;
      op_ubfm:         alu_op = alu_op_ubfm;
      op_sbfm:         alu_op = alu_op_sbfm;
      op_movk:         alu_op = alu_op_mov;
      op_csel:         alu_op = alu_op_csel;
      op_csinc:        alu_op = alu_op_csinc;
      op_csinv:        alu_op = alu_op_csinv;
      op_csneg:        alu_op = alu_op_csneg;
      default:         alu_op = alu_op_plus;
    endcase
  end

  // Memory ops go to the load/store unit.
  assign fu = (opcode inside {op_ldur, op_stur, op_ldp, op_stp}) ? fu_ls : fu_alu;

  // Assemble the micro-op.
  always_comb begin
    uop.pc         = pc;
    uop.opcode     = opcode;
    uop.alu_op     = alu_op;
    uop.fu         = fu;
    uop.src1       = src1;
    uop.src2       = src2;
    uop.dst        = dst;
    uop.imm        = imm;
    // No register result for stores, plain branches and system ops.
    uop.w_enable   = !(opcode inside {op_stur, op_b, op_b_cond, op_ret, op_nop,
                                      op_hlt, op_cbz, op_cbnz, op_br});
    uop.set_cc     = opcode inside {op_adds, op_ands, op_subs};
    uop.dmem_read  = (opcode == op_ldur);
    uop.dmem_write = (opcode == op_stur);
  end

endmodule : insn_decode

`default_nettype wire

/* src/insn_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module insn_queue import core_pkg::*; (
  input  logic       in_clk,
  input  logic       rst_n,
  input  logic       push,
  input  fetch_pkt_t push_pkt,
  input  logic       pop,
  output fetch_pkt_t head_pkt,
  output logic       full,
  output logic       empty
);

  fetch_pkt_t          mem [iq_depth];
  logic [iq_ptr_w-1:0] wr_ptr;
  logic [iq_ptr_w-1:0] rd_ptr;
  logic [iq_ptr_w:0]   count;

  // Storage.
  always_ff @(posedge in_clk) begin
    if (push) begin
      mem[wr_ptr] <= push_pkt;
    end
  end

  // Pointers wrap naturally since the depth is a power of two.
  always_ff @(posedge in_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Push and pop together keep the count.
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head is read asynchronously.
  assign head_pkt = mem[rd_ptr];

  assign full  = (count == (iq_ptr_w + 1)'(iq_depth));
  assign empty = (count == '0);

endmodule : insn_queue

`default_nettype wire

/* src/insn_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module insn_fetch import core_pkg::*; (
  input  logic       in_clk,
  input  logic       rst_n,
  input  wb_s2m_t    wb_in,
  input  logic       full,
  input  logic       halted,
  output wb_m2s_t    wb_out,
  output logic       push,
  output fetch_pkt_t pkt
);

  // Bus controller states.
  typedef enum logic {
    st_idle,
    st_busy
  } bus_state_t;

  bus_state_t  state;
  logic [31:0] pc;
  logic        rd_done;

  // A read ends on the cycle the slave acks.
  assign rd_done = (state == st_busy) && wb_in.ack;

  // Idle always lasts at least one cycle, so cyc drops after every ack.
  always_ff @(posedge in_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      pc    <= reset_vector;
    end else begin
      case (state)
        st_idle: begin
          // Only open a read when the queue has room for the word.
          if (!full && !halted) begin
            state <= st_busy;
          end
        end
        st_busy: begin
          if (wb_in.ack) begin
            state <= st_idle;
            pc    <= pc + 32'd4;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Read-only master, full word lanes.
  always_comb begin
    wb_out.cyc = (state == st_busy);
    wb_out.stb = (state == st_busy);
    wb_out.we  = 1'b0;
    wb_out.adr = pc;
    wb_out.sel = 4'hf;
    wb_out.dat = 32'h0000_0000;
  end

  // The packet is written straight from the ack cycle.
  assign push     = rd_done;
  assign pkt.pc   = pc;
  assign pkt.insn = wb_in.dat;

endmodule : insn_fetch

`default_nettype wire

/* src/core_pkg.sv */
`default_nettype none

package core_pkg;

  // First fetch address after reset.
  localparam logic [31:0] reset_vector = 32'h0000_0000;

  // Instruction queue depth, a power of two.
  localparam int iq_depth = 4;
  localparam int iq_ptr_w = $clog2(iq_depth);

  // Wishbone master to slave.
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [3:0]  sel;
    logic [31:0] dat;
  } wb_m2s_t;

  // Wishbone slave to master.
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_s2m_t;

  // One fetched word and its address.
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] insn;
  } fetch_pkt_t;

  // Decoded micro-op handed to the back end.
  typedef struct packed {
    logic [31:0]                      pc;
    isa_pkg::opcode_t                 opcode;
    isa_pkg::alu_op_t                 alu_op;
    isa_pkg::func_unit_t              fu;
    logic [isa_pkg::gpr_idx_size-1:0] src1;
    logic [isa_pkg::gpr_idx_size-1:0] src2;
    logic [isa_pkg::gpr_idx_size-1:0] dst;
    logic [63:0]                      imm;
    logic                             w_enable;
    logic                             set_cc;
    logic                             dmem_read;
    logic                             dmem_write;
  } uop_t;

endpackage : core_pkg

`default_nettype wire

/* src/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  // Width of a general register index.
  localparam int gpr_idx_size = 5;

  // Decoded instructions of the supported subset.
  typedef enum logic [5:0] {
    // Loads and stores.
    op_ldur,
    op_stur,
    op_ldp,
    op_stp,
    // Moves and PC relative addresses.
    op_movk,
    op_adr,
    op_adrp,
    // Conditional selects.
    op_csel,
    op_csinc,
    op_csinv,
    op_csneg,
    // Integer arithmetic and logic.
    op_add,
    op_adds,
    op_sub,
    op_subs,
    op_orn,
    op_orr,
    op_eor,
    op_and,
    op_ands,
    // Bitfield moves, aliased by the shifts.
    op_ubfm,
    op_sbfm,
    // Branches.
    op_b,
    op_b_cond,
    op_bl,
    op_blr,
    op_br,
    op_cbz,
    op_cbnz,
    op_ret,
    // System.
    op_nop,
    op_hlt,
    // Word that matches no pattern.
    op_err
  } opcode_t;

  // Operation the ALU performs for a micro-op.
  typedef enum logic [3:0] {
    alu_op_plus,
    alu_op_minus,
    alu_op_orn,
    alu_op_or,
    alu_op_eor,
    alu_op_and,
    alu_op_ubfm,
    alu_op_sbfm,
    alu_op_mov,
    alu_op_csel,
    alu_op_csinc,
    alu_op_csinv,
    alu_op_csneg
  } alu_op_t;

  // Functional unit that executes a micro-op.
  typedef enum logic {
    fu_alu,
    fu_ls
  } func_unit_t;

endpackage : isa_pkg

`default_nettype wire
